// File: Makefile
# Verilator build and run for the bit-serial ALU testbench.

SIM = obj_dir/Vtb_serial_alu

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f source/*.sv source/*.svh testbench/*.sv
	verilator --binary --timing --assert -f tb.f --top-module tb_serial_alu

# the simulator keeps going after an assertion error so the testbench can report it.
run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// File: source/bit_sequencer.sv
`timescale 1ns/10ps

`include "serial_alu_settings.svh"

module bit_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output logic                     load,
    output logic                     step,
    output logic                     first_step,
    output logic                     last_step,
    output serial_alu_pkg::bit_idx_t bit_index
);

    localparam serial_alu_pkg::bit_idx_t last_idx =
        serial_alu_pkg::bit_idx_t'(`WORD_WIDTH - 1);

    ///////////////////////////////
    // step strobes
    ///////////////////////////////

    // a start is only taken while the unit is idle.
    assign load = start & ~busy;

    // every busy cycle processes exactly one operand bit.
    assign step       = busy;
    assign first_step = busy & (bit_index == '0);
    assign last_step  = busy & (bit_index == last_idx);

    ///////////////////////////////
    // state and bit counter
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            bit_index <= '0;
        end else if (load) begin
            busy      <= 1'b1;
            bit_index <= '0;
        end else if (step) begin
            if (last_step) begin
                // the counter stops on the last bit and keeps showing it.
                busy <= 1'b0;
            end else begin
                bit_index <= bit_index + 1'b1;
            end
        end
    end

    // done follows the last step by one edge, when the result is final.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= last_step;
        end
    end

endmodule

// File: source/bit_slice_alu.sv
`timescale 1ns/10ps

module bit_slice_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  logic                    step,
    input  logic                    first_step,
    input  serial_alu_pkg::alu_op_e op,
    input  logic                    a_bit,
    input  logic                    b_bit,
    output logic                    res_bit,
    output logic                    carry
);

    serial_alu_pkg::alu_op_e op_q;
    logic                    carry_q;
    logic                    is_sub;
    logic                    is_arith;
    logic                    b_eff;
    logic                    cin;
    logic                    sum;
    logic                    cout;

    ///////////////////////////////
    // opcode and carry registers
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q <= serial_alu_pkg::op_add;
        end else if (load) begin
            op_q <= op;
        end
    end

    // the carry chain runs through this one flop, one bit per step.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (step) begin
            carry_q <= carry;
        end
    end

    ///////////////////////////////
    // one-bit datapath
    ///////////////////////////////

    assign is_sub   = (op_q == serial_alu_pkg::op_sub);
    assign is_arith = (op_q == serial_alu_pkg::op_add) | is_sub;

    // subtract is a + ~b + 1, so b is inverted and bit 0 sees a carry of 1.
    assign b_eff = b_bit ^ is_sub;
    assign cin   = first_step ? is_sub : carry_q;

    assign sum  = a_bit ^ b_eff ^ cin;
    assign cout = (a_bit & b_eff) | (a_bit & cin) | (b_eff & cin);

    // logical ops leave no carry behind.
    assign carry = is_arith & cout;

    always_comb begin
        case (op_q)
            serial_alu_pkg::op_add:   res_bit = sum;
            serial_alu_pkg::op_sub:   res_bit = sum;
            serial_alu_pkg::op_xor:   res_bit = a_bit ^ b_bit;
            serial_alu_pkg::op_and:   res_bit = a_bit & b_bit;
            serial_alu_pkg::op_not_a: res_bit = ~a_bit;
            serial_alu_pkg::op_or:    res_bit = a_bit | b_bit;
            serial_alu_pkg::op_nor:   res_bit = ~(a_bit | b_bit);
            serial_alu_pkg::op_nand:  res_bit = ~(a_bit & b_bit);
            default:                  res_bit = 1'b0;
        endcase
    end

endmodule

// File: source/operand_serializer.sv
`timescale 1ns/10ps

module operand_serializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  logic                     step,
    input  serial_alu_pkg::operand_t a,
    input  serial_alu_pkg::operand_t b,
    output logic                     a_bit,
    output logic                     b_bit
);

    serial_alu_pkg::operand_t a_sr;
    serial_alu_pkg::operand_t b_sr;

    // both operands leave least significant bit first.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_sr <= '0;
            b_sr <= '0;
        end else if (load) begin
            a_sr <= a;
            b_sr <= b;
        end else if (step) begin
            a_sr <= a_sr >> 1;
            b_sr <= b_sr >> 1;
        end
    end

    assign a_bit = a_sr[0];
    assign b_bit = b_sr[0];

endmodule

// File: source/result_deserializer.sv
`timescale 1ns/10ps

`include "serial_alu_settings.svh"

module result_deserializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step,
    input  logic                    last_step,
    input  logic                    res_bit,
    input  logic                    carry,
    output serial_alu_pkg::result_t result
);

    logic [`WORD_WIDTH-2:0] shift_q;

    ///////////////////////////////
    // collection shift register
    ///////////////////////////////

    // bits enter at the top, so after fifteen steps bit 0 sits at position 0.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (step) begin
            shift_q <= {res_bit, shift_q[`WORD_WIDTH-2:1]};
        end
    end

    ///////////////////////////////
    // result word
    ///////////////////////////////

    // the visible result only changes once the last bit and carry are known.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (last_step) begin
            result <= {carry, res_bit, shift_q};
        end
    end

endmodule

// File: source/serial_alu.sv
`timescale 1ns/10ps

module serial_alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  serial_alu_pkg::operand_t a,
    input  serial_alu_pkg::operand_t b,
    input  serial_alu_pkg::alu_op_e  op,
    output serial_alu_pkg::result_t  result,
    output serial_alu_pkg::bit_idx_t bit_index,
    output logic                     busy,
    output logic                     done
);

    logic load;
    logic step;
    logic first_step;
    logic last_step;
    logic a_bit;
    logic b_bit;
    logic res_bit;
    logic carry;

    ///////////////////////////////
    // control
    ///////////////////////////////

    bit_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .load       (load),
        .step       (step),
        .first_step (first_step),
        .last_step  (last_step),
        .bit_index  (bit_index)
    );

    ///////////////////////////////
    // datapath
    ///////////////////////////////

    operand_serializer u_operands (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .step  (step),
        .a     (a),
        .b     (b),
        .a_bit (a_bit),
        .b_bit (b_bit)
    );

    bit_slice_alu u_slice (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .step       (step),
        .first_step (first_step),
        .op         (op),
        .a_bit      (a_bit),
        .b_bit      (b_bit),
        .res_bit    (res_bit),
        .carry      (carry)
    );

    result_deserializer u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .last_step (last_step),
        .res_bit   (res_bit),
        .carry     (carry),
        .result    (result)
    );

endmodule

// File: source/serial_alu_pkg.sv
`include "serial_alu_settings.svh"

package serial_alu_pkg;

    ///////////////////////////////
    // data types
    ///////////////////////////////

    typedef logic [`WORD_WIDTH-1:0] operand_t;

    // bit WORD_WIDTH carries the final carry, or the no-borrow flag on subtract.
    typedef logic [`WORD_WIDTH:0] result_t;

    typedef logic [`BIT_IDX_WIDTH-1:0] bit_idx_t;

    ///////////////////////////////
    // opcodes
    ///////////////////////////////

    // the eight ALU operations in their decode order.
    typedef enum logic [`OP_WIDTH-1:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_xor   = 3'd2,
        op_and   = 3'd3,
        op_not_a = 3'd4,
        op_or    = 3'd5,
        op_nor   = 3'd6,
        op_nand  = 3'd7
    } alu_op_e;

endpackage

// File: source/serial_alu_settings.svh
`ifndef SERIAL_ALU_SETTINGS_SVH
`define SERIAL_ALU_SETTINGS_SVH

// the operand is one machine word wide.
`define WORD_WIDTH 16

// opcode width for the eight supported operations.
`define OP_WIDTH 3

// the bit counter is wide enough to index every operand bit.
`define BIT_IDX_WIDTH 4

`endif

// File: tb.f
+incdir+source
source/serial_alu_pkg.sv
source/bit_sequencer.sv
source/operand_serializer.sv
source/bit_slice_alu.sv
source/result_deserializer.sv
source/serial_alu.sv
testbench/serial_alu_chk.sv
testbench/tb_serial_alu.sv

// File: testbench/serial_alu_chk.sv
`timescale 1ns/10ps

module serial_alu_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input serial_alu_pkg::operand_t a,
    input serial_alu_pkg::operand_t b,
    input serial_alu_pkg::alu_op_e  op,
    input serial_alu_pkg::result_t  result,
    input serial_alu_pkg::bit_idx_t bit_index,
    input logic                     busy,
    input logic                     done
);

    serial_alu_pkg::operand_t cap_a;
    serial_alu_pkg::operand_t cap_b;
    serial_alu_pkg::alu_op_e  cap_op;
    serial_alu_pkg::result_t  exp_result;
    logic [4:0]               run_cnt;
    logic                     started;
    logic                     accepted;
    int                       error_count = 0;

    // the expected result follows the opcode table of the ALU.
    function automatic serial_alu_pkg::result_t expected_result(
        input serial_alu_pkg::operand_t x,
        input serial_alu_pkg::operand_t y,
        input serial_alu_pkg::alu_op_e  o
    );
        serial_alu_pkg::result_t r;
        case (o)
            serial_alu_pkg::op_add:   r = {1'b0, x} + {1'b0, y};
            serial_alu_pkg::op_sub:   r = {(x >= y), x - y};
            serial_alu_pkg::op_xor:   r = {1'b0, x ^ y};
            serial_alu_pkg::op_and:   r = {1'b0, x & y};
            serial_alu_pkg::op_not_a: r = {1'b0, ~x};
            serial_alu_pkg::op_or:    r = {1'b0, x | y};
            serial_alu_pkg::op_nor:   r = {1'b0, ~(x | y)};
            serial_alu_pkg::op_nand:  r = {1'b0, ~(x & y)};
            default:                  r = '0;
        endcase
        return r;
    endfunction

    //////////////////////////////
    // transaction tracking
    //////////////////////////////

    assign accepted   = start & ~busy;
    assign exp_result = expected_result(cap_a, cap_b, cap_op);

    // run_cnt equals the number of edges since the accepted start.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cap_a   <= '0;
            cap_b   <= '0;
            cap_op  <= serial_alu_pkg::op_add;
            run_cnt <= '0;
            started <= 1'b0;
        end else if (accepted) begin
            cap_a   <= a;
            cap_b   <= b;
            cap_op  <= op;
            run_cnt <= 5'd1;
            started <= 1'b1;
        end else if (run_cnt == 5'd17) begin
            run_cnt <= '0;
        end else if (run_cnt != 5'd0) begin
            run_cnt <= run_cnt + 5'd1;
        end
    end

    //////////////////////////////
    // result checks
    //////////////////////////////

    add_result: assert property (@(posedge clk) disable iff (!rst_n)
        done && cap_op == serial_alu_pkg::op_add |-> result == exp_result)
    else begin
        $error("mismatch add expected %h actual %h", $sampled(exp_result), $sampled(result));
        error_count++;
    end

    sub_result: assert property (@(posedge clk) disable iff (!rst_n)
        done && cap_op == serial_alu_pkg::op_sub |-> result == exp_result)
    else begin
        $error("mismatch sub expected %h actual %h", $sampled(exp_result), $sampled(result));
        error_count++;
    end

    logic_result: assert property (@(posedge clk) disable iff (!rst_n)
        done && cap_op != serial_alu_pkg::op_add && cap_op != serial_alu_pkg::op_sub
        |-> result == exp_result)
    else begin
        $error("mismatch logic_op%0d expected %h actual %h", $sampled(cap_op),
               $sampled(exp_result), $sampled(result));
        error_count++;
    end

    //////////////////////////////
    // timing checks
    //////////////////////////////

    done_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        run_cnt == 5'd17 |-> done)
    else begin
        $error("done did not rise sixteen cycles after an accepted start");
        error_count++;
    end

    // this also catches a done caused by a start that arrived while busy.
    done_only_once: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> run_cnt == 5'd17)
    else begin
        $error("done was high outside the one cycle that ends a transaction");
        error_count++;
    end

    busy_during_run: assert property (@(posedge clk) disable iff (!rst_n)
        run_cnt >= 5'd1 && run_cnt <= 5'd16 |-> busy)
    else begin
        $error("busy dropped before all sixteen bits were processed");
        error_count++;
    end

    busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $fell(busy))
    else begin
        $error("busy did not fall on the edge where done rose");
        error_count++;
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !busy && !done && result == '0 && bit_index == '0)
    else begin
        $error("outputs were not cleared by reset before the first start");
        error_count++;
    end

endmodule

bind serial_alu serial_alu_chk u_chk (.*);

// File: testbench/tb_serial_alu.sv
`timescale 1ns/10ps

module tb_serial_alu;

    localparam int num_transactions = 40;
    localparam int reset_cycles     = 4;
    localparam int timeout_cycles   = num_transactions * 18 + reset_cycles + 100;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    serial_alu_pkg::operand_t a;
    serial_alu_pkg::operand_t b;
    serial_alu_pkg::alu_op_e  op;
    serial_alu_pkg::result_t  result;
    serial_alu_pkg::bit_idx_t bit_index;
    logic                     busy;
    logic                     done;

    int          cycle_count = 0;
    logic [31:0] rng = 32'hfa8a47d5;

    serial_alu uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .a         (a),
        .b         (b),
        .op        (op),
        .result    (result),
        .bit_index (bit_index),
        .busy      (busy),
        .done      (done)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // issues one start and returns once done is seen high.
    // a nonzero poke_cycle pulses start again that many cycles into the run.
    task automatic run_transaction(
        input serial_alu_pkg::operand_t ta,
        input serial_alu_pkg::operand_t tb_val,
        input serial_alu_pkg::alu_op_e  top,
        input int                       poke_cycle
    );
        int waited;
        waited = 0;
        a      = ta;
        b      = tb_val;
        op     = top;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited == poke_cycle) begin
                start = 1'b1;
                a     = ~ta;
                b     = ta ^ tb_val;
                op    = (top == serial_alu_pkg::op_nand) ? serial_alu_pkg::op_add
                                                         : serial_alu_pkg::op_nand;
            end else begin
                start = 1'b0;
            end
        end
    endtask

    //////////////////////////////
    // watchdogs
    //////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count == timeout_cycles);
        $display("TB FAILED");
        $fatal(1, "timeout: the test did not finish within %0d cycles", timeout_cycles);
    end

    initial begin
        wait (uut.u_chk.error_count != 0);
        #1;
        $display("TB FAILED");
        $fatal(1, "a result or timing assertion failed");
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        serial_alu_pkg::operand_t ra;
        serial_alu_pkg::operand_t rb;
        serial_alu_pkg::alu_op_e  rop;
        int                       poke;

        clk   = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        a     = '0;
        b     = '0;
        op    = serial_alu_pkg::op_add;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        // corner cases for the borrow and carry paths.
        run_transaction(16'h0000, 16'h0000, serial_alu_pkg::op_sub, 0);
        run_transaction(16'hffff, 16'h0001, serial_alu_pkg::op_add, 0);

        // every opcode twice with random operands.
        for (int i = 0; i < 16; i++) begin
            rng = lcg_next(rng);
            ra  = rng[31:16];
            rng = lcg_next(rng);
            rb  = rng[31:16];
            rop = serial_alu_pkg::alu_op_e'(i[2:0]);
            run_transaction(ra, rb, rop, 0);
        end

        // random opcodes, one of them hit by a start while busy.
        for (int i = 0; i < num_transactions - 18; i++) begin
            rng  = lcg_next(rng);
            ra   = rng[31:16];
            rng  = lcg_next(rng);
            rb   = rng[31:16];
            rng  = lcg_next(rng);
            rop  = serial_alu_pkg::alu_op_e'(rng[18:16]);
            poke = (i == 10) ? 6 : 0;
            run_transaction(ra, rb, rop, poke);
        end

        // give the checker the edges on which it samples the last done.
        repeat (2) @(posedge clk);
        #1;

        if (uut.u_chk.error_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "assertions failed during the run");
        end
    end

endmodule
